// File: Makefile
# Verilator build and run of the AHB RAM subsystem testbench

LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps \
	  --top-module tb_ahb_ram -Mdir obj_dir -f files.f
	./obj_dir/Vtb_ahb_ram | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

// File: files.f
+incdir+source
source/ahb_pkg.sv
source/ahb_bus_if.sv
source/ram_req_if.sv
source/ahb_master.sv
source/ahb_slave_fsm.sv
source/wait_timer.sv
source/sram_array.sv
source/ahb_ram_top.sv
sim/tb_ahb_ram.sv

// File: sim/tb_ahb_ram.sv
//////////////////////////////////////////////////////////////////////
// AHB RAM subsystem testbench
// Directed and random requester traffic against a reference memory,
// with the HREADY stall length checked on every transfer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none
`include "ahb_params.svh"

module tb_ahb_ram;

  localparam int IDX_W       = $clog2(`MEM_WORDS);
  localparam int N_RAND      = 200;                       // Random transfers
  localparam int N_XFERS     = N_RAND + 20;               // All transfers, rounded up
  localparam int WATCHDOG_NS = N_XFERS * (`WAIT_STATES + 2) * 4 + 400;

  logic                   CLK;
  logic                   arst_n;
  logic                   ren;
  logic                   wen;
  logic [`AHB_ADDR_W-1:0] addr;
  logic [`AHB_DATA_W-1:0] wdata;
  logic [`AHB_DATA_W-1:0] rdata;
  logic                   busy;

  logic [`AHB_DATA_W-1:0] model [`MEM_WORDS];             // Reference memory
  integer                 seed;                           // $random state
  logic                   pend_valid;                     // Transfer in flight
  logic                   pend_read;
  logic [IDX_W-1:0]       pend_idx;
  logic [`AHB_DATA_W-1:0] pend_data;
  string                  pend_name;
  int                     stall_left  = 0;                // Busy cycles still due
  bit                     expect_done = 1'b0;             // Completion cycle due

  ahb_ram_top uut (
    .CLK    (CLK),
    .arst_n (arst_n),
    .ren    (ren),
    .wen    (wen),
    .addr   (addr),
    .wdata  (wdata),
    .rdata  (rdata),
    .busy   (busy)
  );

  initial
  begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;                                // 4 ns period
  end

  initial
  begin
    #(WATCHDOG_NS);
    abort_run("Watchdog expired before all transfers finished");
  end

  //////////////////////////////////////////////////////////////////////
  // Error reporting and helpers
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic flag_mismatch(input string name, input logic [`AHB_DATA_W-1:0] exp_val,
                               input logic [`AHB_DATA_W-1:0] act_val);
    abort_run($sformatf("CHECK FAILED %s: expected 0x%08h, actual 0x%08h",
                        name, exp_val, act_val));
  endtask

  function automatic logic [`AHB_ADDR_W-1:0] word_addr(input logic [IDX_W-1:0] idx);
    return `AHB_ADDR_W'({idx, 2'b00});                   // Byte lanes zero
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stall timing monitor
  //////////////////////////////////////////////////////////////////////

  always @(negedge CLK)
  begin
    if (arst_n)
    begin
      if (stall_left > 0)
      begin
        assert (busy === 1'b1)
          else flag_mismatch("stall timing", `AHB_DATA_W'(1), `AHB_DATA_W'(busy));
        stall_left  = stall_left - 1;
        expect_done = (stall_left == 0);
      end
      else
      begin
        // Completion cycle or idle bus
        assert (busy === 1'b0)
          else flag_mismatch(expect_done ? "stall length" : "idle busy", '0,
                             `AHB_DATA_W'(busy));
        expect_done = 1'b0;
      end
      if ((ren || wen) && !busy)                          // Taken at the next edge
        stall_left = `WAIT_STATES;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Requester driver
  //////////////////////////////////////////////////////////////////////

  task automatic complete_transfer();
    assert (busy === 1'b0)
      else flag_mismatch({pend_name, " completion"}, '0, `AHB_DATA_W'(busy));
    if (pend_read)
    begin
      assert (rdata === model[pend_idx])
        else flag_mismatch(pend_name, model[pend_idx], rdata);
    end
    else
      model[pend_idx] = pend_data;                        // Lands at closing edge
  endtask

  task automatic issue_transfer(input string name, input logic r, input logic w,
                                input logic [IDX_W-1:0] idx,
                                input logic [`AHB_DATA_W-1:0] d);
    @(posedge CLK);                                       // Completion cycle starts
    ren   <= r;
    wen   <= w;
    addr  <= word_addr(idx);
    wdata <= (pend_valid && !pend_read) ? pend_data : d;  // Write in data phase keeps HWDATA
    @(negedge CLK);
    if (pend_valid)
      complete_transfer();
    @(posedge CLK);                                       // New request taken here
    wdata      <= d;
    pend_valid = r || w;
    pend_read  = r;                                       // ren wins
    pend_idx   = idx;
    pend_data  = d;
    pend_name  = name;
    if (pend_valid)
      repeat (`WAIT_STATES) @(negedge CLK);              // Stall cycles
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int                     wr_list [$];                  // Word indices written
    int                     pick;
    logic [IDX_W-1:0]       idx;
    logic [`AHB_DATA_W-1:0] d1;

    seed       = 42520;
    arst_n     = 1'b0;
    ren        = 1'b0;
    wen        = 1'b0;
    addr       = '0;
    wdata      = '0;
    pend_valid = 1'b0;
    pend_read  = 1'b0;
    pend_idx   = '0;
    pend_data  = '0;
    pend_name  = "";
    repeat (5) @(posedge CLK);
    arst_n <= 1'b1;

    repeat (4)                                            // Quiet bus after reset
    begin
      @(negedge CLK);
      assert (busy === 1'b0)
        else flag_mismatch("idle after reset", '0, `AHB_DATA_W'(busy));
    end

    idx = IDX_W'($unsigned($random(seed)));
    d1  = $random(seed);
    issue_transfer("write then read", 1'b0, 1'b1, idx, d1);
    issue_transfer("write then read", 1'b1, 1'b0, idx, '0);
    issue_transfer("idle", 1'b0, 1'b0, '0, '0);
    wr_list.push_back(int'(idx));

    for (int n = 0; n < N_RAND; n++)
    begin
      if ($random(seed) % 2 == 0)
      begin
        idx = IDX_W'($unsigned($random(seed)));
        wr_list.push_back(int'(idx));
        issue_transfer("random write", 1'b0, 1'b1, idx, $random(seed));
      end
      else
      begin
        pick = int'($unsigned($random(seed)) % wr_list.size());   // Known words only
        issue_transfer("random read", 1'b1, 1'b0, IDX_W'(wr_list[pick]), $random(seed));
      end
    end

    idx = IDX_W'($unsigned($random(seed)));              // Last write wins
    for (int k = 0; k < 3; k++)
      issue_transfer("back-to-back write", 1'b0, 1'b1, idx, $random(seed));
    issue_transfer("back-to-back readback", 1'b1, 1'b0, idx, '0);

    d1 = $random(seed);
    issue_transfer("write before dual request", 1'b0, 1'b1, idx, d1);
    issue_transfer("ren and wen together", 1'b1, 1'b1, idx, ~d1);
    issue_transfer("memory after dual request", 1'b1, 1'b0, idx, '0);
    issue_transfer("idle", 1'b0, 1'b0, '0, '0);

    repeat (4) @(negedge CLK);                            // Bus settles idle
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: source/ahb_bus_if.sv
//////////////////////////////////////////////////////////////////////
// AHB-Lite bus interface
// Single-slave bus between the master and the RAM slave
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none
`include "ahb_params.svh"

interface ahb_bus_if;

  ahb_pkg::htrans_t        HTRANS;        // Transfer type
  logic                    HWRITE;        // 1 = write
  logic [`AHB_ADDR_W-1:0]  HADDR;         // Byte address
  logic [`AHB_DATA_W-1:0]  HWDATA;        // Write data
  ahb_pkg::hsize_t         HSIZE;         // Transfer size
  logic [2:0]              HBURST;        // Tied to single
  logic [3:0]              HPROT;         // Tied off
  logic                    HMASTLOCK;     // Tied off
  logic [`AHB_DATA_W-1:0]  HRDATA;        // Read data
  logic                    HREADY;        // Low stalls the master

  modport master (
    output HTRANS, HWRITE, HADDR, HWDATA, HSIZE, HBURST, HPROT, HMASTLOCK,
    input  HRDATA, HREADY
  );

  modport slave (
    input  HTRANS, HWRITE, HADDR, HWDATA, HSIZE, HBURST, HPROT, HMASTLOCK,
    output HRDATA, HREADY
  );

endinterface

`default_nettype wire

// File: source/ahb_master.sv
//////////////////////////////////////////////////////////////////////
// AHB-Lite master
// Maps held read/write requests onto single NONSEQ transfers
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module ahb_master (
  input  logic       CLK,                 // Unused, combinational block
  input  logic       arst_n,              // Unused, combinational block
  ahb_bus_if.master  ahb_m,
  ram_req_if.mem     req
);

  //////////////////////////////////////////////////////////////////////
  // Address and control phase
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    // Fixed fields for every transfer
    ahb_m.HBURST    = '0;                // Single only
    ahb_m.HPROT     = '0;
    ahb_m.HMASTLOCK = 1'b0;

    if (req.ren)                         // Read first
    begin
      ahb_m.HTRANS = ahb_pkg::NONSEQ;
      ahb_m.HWRITE = 1'b0;
      ahb_m.HADDR  = req.addr;
      ahb_m.HWDATA = req.wdata;          // Ignored by slave on reads
      ahb_m.HSIZE  = ahb_pkg::WORD;
    end
    else if (req.wen)
    begin
      ahb_m.HTRANS = ahb_pkg::NONSEQ;
      ahb_m.HWRITE = 1'b1;
      ahb_m.HADDR  = req.addr;
      ahb_m.HWDATA = req.wdata;          // Held through data phase
      ahb_m.HSIZE  = ahb_pkg::WORD;
    end
    else                                 // Bus idle, zeros
    begin
      ahb_m.HTRANS = ahb_pkg::IDLE;
      ahb_m.HWRITE = 1'b0;
      ahb_m.HADDR  = '0;
      ahb_m.HWDATA = '0;
      ahb_m.HSIZE  = ahb_pkg::BYTE;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response back to requester
  //////////////////////////////////////////////////////////////////////

  assign req.busy  = ~ahb_m.HREADY;      // Stall seen as busy
  assign req.rdata = ahb_m.HRDATA;       // Valid when busy drops

endmodule

`default_nettype wire

// File: source/ahb_params.svh
//////////////////////////////////////////////////////////////////////
// AHB RAM subsystem parameters
// Bus widths, SRAM depth and slave wait-state count
//////////////////////////////////////////////////////////////////////

`ifndef AHB_PARAMS_SVH
`define AHB_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////////////////////////

`define AHB_ADDR_W 32                // Byte address width
`define AHB_DATA_W 32                // Word width, single size only

//////////////////////////////////////////////////////////////////////
// Slave memory
//////////////////////////////////////////////////////////////////////

`define MEM_WORDS 64                 // SRAM depth in words

// Stall cycles per transfer, keep at 1 or more
`define WAIT_STATES 2

`endif

// File: source/ahb_pkg.sv
//////////////////////////////////////////////////////////////////////
// AHB-Lite type package
// Transfer type, size and slave state encodings
//////////////////////////////////////////////////////////////////////

`default_nettype none

package ahb_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus encodings
  //////////////////////////////////////////////////////////////////////

  // HTRANS, only the two single-transfer codes are used
  typedef enum logic [1:0] {
    IDLE   = 2'b00,                  // No transfer
    NONSEQ = 2'b10                   // Single transfer
  } htrans_t;

  // HSIZE, master issues word transfers only
  typedef enum logic [2:0] {
    BYTE = 3'b000,                   // Idle default
    WORD = 3'b010                    // 32-bit transfer
  } hsize_t;

  //////////////////////////////////////////////////////////////////////
  // Slave control
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    S_IDLE = 2'b00,                  // Ready, waiting for NONSEQ
    S_WAIT = 2'b01,                  // HREADY low, timer running
    S_DATA = 2'b10                   // Data phase, one cycle
  } slave_state_t;

endpackage

`default_nettype wire

// File: source/ahb_ram_top.sv
//////////////////////////////////////////////////////////////////////
// AHB RAM subsystem top
// Requester ports into the AHB-Lite master, slave FSM, timer and SRAM
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none
`include "ahb_params.svh"

module ahb_ram_top (
  input  logic                   CLK,
  input  logic                   arst_n,
  input  logic                   ren,     // Read request
  input  logic                   wen,     // Write request
  input  logic [`AHB_ADDR_W-1:0] addr,    // Byte address
  input  logic [`AHB_DATA_W-1:0] wdata,
  output logic [`AHB_DATA_W-1:0] rdata,
  output logic                   busy     // Transfer in progress
);

  logic                          timer_start;
  logic                          timer_done;
  logic                          mem_we;
  logic [$clog2(`MEM_WORDS)-1:0] mem_index;
  logic [`AHB_DATA_W-1:0]        mem_rdata;

  ahb_bus_if bus ();                      // Master to slave
  ram_req_if req_if ();                   // Requester side

  //////////////////////////////////////////////////////////////////////
  // Requester ports
  //////////////////////////////////////////////////////////////////////

  assign req_if.ren   = ren;
  assign req_if.wen   = wen;
  assign req_if.addr  = addr;
  assign req_if.wdata = wdata;
  assign rdata        = req_if.rdata;
  assign busy         = req_if.busy;

  //////////////////////////////////////////////////////////////////////
  // Master, slave and storage
  //////////////////////////////////////////////////////////////////////

  ahb_master u_master (
    .CLK    (CLK),
    .arst_n (arst_n),
    .ahb_m  (bus.master),
    .req    (req_if.mem)
  );

  ahb_slave_fsm u_slave_fsm (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .ahb_s       (bus.slave),
    .timer_start (timer_start),
    .timer_done  (timer_done),
    .mem_we      (mem_we),
    .mem_index   (mem_index),
    .mem_rdata   (mem_rdata)
  );

  wait_timer u_wait_timer (
    .CLK    (CLK),
    .arst_n (arst_n),
    .start  (timer_start),
    .done   (timer_done)
  );

  sram_array u_sram (
    .CLK   (CLK),
    .we    (mem_we),
    .index (mem_index),
    .wdata (bus.HWDATA),                  // Master holds it through data phase
    .rdata (mem_rdata)
  );

endmodule

`default_nettype wire

// File: source/ahb_slave_fsm.sv
//////////////////////////////////////////////////////////////////////
// AHB-Lite RAM slave control
// Accepts a transfer, stalls HREADY for the wait states, then runs
// the one-cycle data phase against the SRAM array
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none
`include "ahb_params.svh"

module ahb_slave_fsm (
  input  logic                          CLK,
  input  logic                          arst_n,
  ahb_bus_if.slave                      ahb_s,
  output logic                          timer_start,   // Load wait timer
  input  logic                          timer_done,    // Last wait cycle
  output logic                          mem_we,        // Array write strobe
  output logic [$clog2(`MEM_WORDS)-1:0] mem_index,     // Word index
  input  logic [`AHB_DATA_W-1:0]        mem_rdata      // Array read data
);

  localparam int IDX_W = $clog2(`MEM_WORDS);

  ahb_pkg::slave_state_t state_q;                 // Current state
  ahb_pkg::slave_state_t state_d;                 // Next state
  logic                  write_q;                 // Latched HWRITE
  logic [IDX_W-1:0]      index_q;                 // Latched word index
  logic                  accept;                  // NONSEQ seen while ready

  //////////////////////////////////////////////////////////////////////
  // Transfer acceptance
  //////////////////////////////////////////////////////////////////////

  // New transfer only when HREADY is high, i.e. IDLE or DATA
  assign accept = (ahb_s.HTRANS == ahb_pkg::NONSEQ) &&
                  ((state_q == ahb_pkg::S_IDLE) || (state_q == ahb_pkg::S_DATA));

  assign timer_start = accept;            // Timer loads on the same edge

  always_comb
  begin
    state_d = state_q;                    // Hold by default
    case (state_q)
      ahb_pkg::S_IDLE:
        if (accept)
          state_d = ahb_pkg::S_WAIT;
      ahb_pkg::S_WAIT:
        if (timer_done)                   // Wait states used up
          state_d = ahb_pkg::S_DATA;
      ahb_pkg::S_DATA:
        state_d = accept ? ahb_pkg::S_WAIT : ahb_pkg::S_IDLE;  // Back-to-back
      default:
        state_d = ahb_pkg::S_IDLE;
    endcase
  end

  always_ff @(posedge CLK or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q <= ahb_pkg::S_IDLE;
      write_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (accept)
        write_q <= ahb_s.HWRITE;          // Direction for data phase
    end
  end

  // Word address, byte lanes dropped
  always_ff @(posedge CLK)
  begin
    if (accept)
      index_q <= ahb_s.HADDR[IDX_W+1:2];
  end

  //////////////////////////////////////////////////////////////////////
  // Data phase outputs
  //////////////////////////////////////////////////////////////////////

  assign ahb_s.HREADY = (state_q != ahb_pkg::S_WAIT);   // Low only while waiting
  assign mem_we       = (state_q == ahb_pkg::S_DATA) && write_q;
  assign mem_index    = index_q;

  // Read data only on read data phase
  assign ahb_s.HRDATA = ((state_q == ahb_pkg::S_DATA) && !write_q) ? mem_rdata : '0;

endmodule

`default_nettype wire

// File: source/ram_req_if.sv
//////////////////////////////////////////////////////////////////////
// RAM-style requester interface
// Held read/write levels in, read data and busy back
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none
`include "ahb_params.svh"

interface ram_req_if;

  logic                    ren;           // Read request, wins over wen
  logic                    wen;           // Write request
  logic [`AHB_ADDR_W-1:0]  addr;          // Byte address
  logic [`AHB_DATA_W-1:0]  wdata;         // Write data
  logic [`AHB_DATA_W-1:0]  rdata;         // Valid in completion cycle
  logic                    busy;          // High while stalled

  modport req (output ren, wen, addr, wdata, input rdata, busy);
  modport mem (input ren, wen, addr, wdata, output rdata, busy);

endinterface

`default_nettype wire

// File: source/sram_array.sv
//////////////////////////////////////////////////////////////////////
// SRAM array
// Word storage, write on clock edge, asynchronous read
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none
`include "ahb_params.svh"

module sram_array (
  input  logic                          CLK,
  input  logic                          we,      // Write strobe
  input  logic [$clog2(`MEM_WORDS)-1:0] index,   // Word index
  input  logic [`AHB_DATA_W-1:0]        wdata,
  output logic [`AHB_DATA_W-1:0]        rdata
);

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  logic [`AHB_DATA_W-1:0] mem [`MEM_WORDS];       // Contents random at power-up

  always_ff @(posedge CLK)
  begin
    if (we)
      mem[index] <= wdata;                // Commits at end of data phase
  end

  //////////////////////////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////////////////////////

  assign rdata = mem[index];              // Same cycle as index

endmodule

`default_nettype wire

// File: source/wait_timer.sv
//////////////////////////////////////////////////////////////////////
// Wait-state timer
// Down-counter, done marks the last stall cycle of a transfer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none
`include "ahb_params.svh"

module wait_timer (
  input  logic CLK,
  input  logic arst_n,
  input  logic start,                     // Reload, new transfer
  output logic done                       // High in last wait cycle
);

  localparam int CNT_W = $clog2(`WAIT_STATES + 1);

  logic [CNT_W-1:0] count_q;              // Wait cycles left, 0 = idle

  always_ff @(posedge CLK or negedge arst_n)
  begin
    if (!arst_n)
      count_q <= '0;                      // Idle
    else if (start)                       // Start wins over done
      count_q <= CNT_W'(`WAIT_STATES);
    else if (count_q != '0)
      count_q <= count_q - 1'b1;
  end

  assign done = (count_q == CNT_W'(1));   // One cycle left

endmodule

`default_nettype wire
